// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache
BUILD_DIR ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
common/dcache_pkg.sv
logic/dcache_hit_select.sv
dcache/dcache_way.sv
dcache/dcache_ctrl.sv
dcache/dcache_top.sv
tb/wb_mem_model.sv
tb/tb_dcache.sv

// File: common/dcache_pkg.sv
package dcache_pkg;

  // ========================================
  // cache geometry
  // ========================================

  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned WORD_WIDTH = 32;

  // two ways, 16 sets, 16-byte lines
  localparam int unsigned WAY_NUM    = 2;
  localparam int unsigned IDX_WIDTH  = 4;
  localparam int unsigned LINE_WORDS = 4;

  // byte offset inside a line
  localparam int unsigned OFS_WIDTH  = 4;
  localparam int unsigned TAG_WIDTH  = 24;

  // word number inside a line
  localparam int unsigned WORD_SEL_WIDTH = 2;

  // ========================================
  // vector types
  // ========================================

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [WORD_WIDTH-1:0] word_t;

  // word 0 sits in the low bits
  typedef logic [LINE_WORDS*WORD_WIDTH-1:0] line_t;

  typedef logic [TAG_WIDTH-1:0] tag_t;
  typedef logic [IDX_WIDTH-1:0] idx_t;
  typedef logic [WORD_SEL_WIDTH-1:0] wsel_t;
  typedef logic [$clog2(WAY_NUM)-1:0] way_t;
  typedef logic [WORD_WIDTH/8-1:0] strb_t;

  // access size of a load or store
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } mem_size_e;

endpackage

// File: dcache/dcache_ctrl.sv
module dcache_ctrl (
  input  logic                           clk,
  input  logic                           rst_n,
  // core request
  input  logic                           req_valid_i,
  input  logic                           req_we_i,
  input  dcache_pkg::addr_t              req_addr_i,
  input  dcache_pkg::mem_size_e          req_size_i,
  input  logic                           req_signed_i,
  input  dcache_pkg::word_t              req_wdata_i,
  output logic                           req_ready_o,
  output logic                           rsp_valid_o,
  // way control
  output dcache_pkg::idx_t               idx_o,
  output dcache_pkg::tag_t               lookup_tag_o,
  output logic [dcache_pkg::WAY_NUM-1:0] way_we_o,
  output dcache_pkg::tag_t               wr_tag_o,
  output dcache_pkg::line_t              wr_line_o,
  output logic                           wr_dirty_o,
  output dcache_pkg::way_t               victim_way_o,
  // from hit selector
  input  logic                           hit_i,
  input  dcache_pkg::way_t               hit_way_i,
  input  logic                           victim_dirty_i,
  input  dcache_pkg::tag_t               victim_tag_i,
  input  dcache_pkg::line_t              sel_line_i,
  // wishbone master
  output logic                           wb_cyc_o,
  output logic                           wb_stb_o,
  output logic                           wb_we_o,
  output dcache_pkg::addr_t              wb_adr_o,
  output dcache_pkg::word_t              wb_dat_o,
  output dcache_pkg::strb_t              wb_sel_o,
  input  dcache_pkg::word_t              wb_dat_i,
  input  logic                           wb_ack_i,
  // load extraction
  output dcache_pkg::wsel_t              wsel_o,
  output dcache_pkg::mem_size_e          size_o,
  output logic                           signed_o,
  output logic [1:0]                     byte_ofs_o
);

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITEBACK,
    REFILL,
    FILL
  } dcache_state_e;

  dcache_state_e state_q;
  dcache_state_e state_d;

  // held request
  logic                  req_we_q;
  dcache_pkg::addr_t     req_addr_q;
  dcache_pkg::mem_size_e req_size_q;
  logic                  req_signed_q;
  dcache_pkg::word_t     req_wdata_q;

  logic [2**dcache_pkg::IDX_WIDTH-1:0] plru_q;
  dcache_pkg::wsel_t word_cnt_q;
  dcache_pkg::line_t refill_buf_q;

  logic last_ack;
  dcache_pkg::strb_t store_strb;
  dcache_pkg::word_t store_data;
  dcache_pkg::word_t old_word;
  dcache_pkg::word_t merged_word;
  dcache_pkg::line_t merged_line;

  // ========================================
  // address fields
  // ========================================

  assign idx_o        = req_addr_q[dcache_pkg::OFS_WIDTH +: dcache_pkg::IDX_WIDTH];
  assign lookup_tag_o = req_addr_q[dcache_pkg::ADDR_WIDTH-1 -: dcache_pkg::TAG_WIDTH];
  assign wsel_o       = req_addr_q[dcache_pkg::OFS_WIDTH-1:2];
  assign byte_ofs_o   = req_addr_q[1:0];
  assign size_o       = req_size_q;
  assign signed_o     = req_signed_q;

  assign victim_way_o = plru_q[idx_o];

  // core handshake
  assign req_ready_o = (state_q == IDLE);
  assign rsp_valid_o = (state_q == LOOKUP) && hit_i;

  // request payload captured on accept
  always_ff @(posedge clk) begin
    if (req_valid_i && req_ready_o) begin
      req_we_q     <= req_we_i;
      req_addr_q   <= req_addr_i;
      req_size_q   <= req_size_i;
      req_signed_q <= req_signed_i;
      req_wdata_q  <= req_wdata_i;
    end
  end

  // ========================================
  // state machine
  // ========================================

  assign last_ack = wb_ack_i && (word_cnt_q == dcache_pkg::wsel_t'(dcache_pkg::LINE_WORDS - 1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_valid_i) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        if (hit_i) begin
          state_d = IDLE;
        end else if (victim_dirty_i) begin
          state_d = WRITEBACK;
        end else begin
          state_d = REFILL;
        end
      end
      WRITEBACK: begin
        if (last_ack) begin
          state_d = REFILL;
        end
      end
      REFILL: begin
        if (last_ack) begin
          state_d = FILL;
        end
      end
      FILL: begin
        state_d = LOOKUP;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= IDLE;
      word_cnt_q <= '0;
      plru_q     <= '0;
    end else begin
      state_q <= state_d;
      // 2-bit counter wraps back to 0 after a full burst
      if (wb_ack_i && wb_cyc_o) begin
        word_cnt_q <= word_cnt_q + dcache_pkg::wsel_t'(1);
      end
      // move victim pointer away from the way just hit
      if (state_q == LOOKUP && hit_i && plru_q[idx_o] == hit_way_i) begin
        plru_q[idx_o] <= ~hit_way_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == REFILL && wb_ack_i) begin
      refill_buf_q[word_cnt_q*dcache_pkg::WORD_WIDTH +: dcache_pkg::WORD_WIDTH] <= wb_dat_i;
    end
  end

  // ========================================
  // store merge
  // ========================================

  always_comb begin
    store_strb = '1;
    store_data = req_wdata_q;
    case (req_size_q)
      dcache_pkg::SIZE_BYTE: begin
        store_strb = dcache_pkg::strb_t'(4'b0001) << req_addr_q[1:0];
        store_data = {4{req_wdata_q[7:0]}};
      end
      dcache_pkg::SIZE_HALF: begin
        store_strb = dcache_pkg::strb_t'(4'b0011) << req_addr_q[1:0];
        store_data = {2{req_wdata_q[15:0]}};
      end
      default: begin
        store_strb = '1;
        store_data = req_wdata_q;
      end
    endcase

    old_word = sel_line_i[wsel_o*dcache_pkg::WORD_WIDTH +: dcache_pkg::WORD_WIDTH];
    merged_word = old_word;
    for (int b = 0; b < dcache_pkg::WORD_WIDTH / 8; b++) begin
      merged_word[b*8 +: 8] = store_strb[b] ? store_data[b*8 +: 8] : old_word[b*8 +: 8];
    end
    merged_line = sel_line_i;
    merged_line[wsel_o*dcache_pkg::WORD_WIDTH +: dcache_pkg::WORD_WIDTH] = merged_word;
  end

  // way writes for a store hit in LOOKUP or a new line in FILL
  always_comb begin
    way_we_o = '0;
    if (state_q == LOOKUP && hit_i && req_we_q) begin
      way_we_o[hit_way_i] = 1'b1;
    end else if (state_q == FILL) begin
      way_we_o[victim_way_o] = 1'b1;
    end
  end

  assign wr_tag_o   = lookup_tag_o;
  assign wr_line_o  = (state_q == FILL) ? refill_buf_q : merged_line;
  assign wr_dirty_o = (state_q == LOOKUP);

  // ========================================
  // wishbone master
  // ========================================

  assign wb_cyc_o = (state_q == WRITEBACK) || (state_q == REFILL);
  assign wb_stb_o = wb_cyc_o;
  assign wb_we_o  = (state_q == WRITEBACK);
  assign wb_sel_o = '1;

  // victim address on write-back and request address on refill
  assign wb_adr_o = (state_q == WRITEBACK) ? {victim_tag_i, idx_o, word_cnt_q, 2'b00} :
                                             {lookup_tag_o, idx_o, word_cnt_q, 2'b00};
  assign wb_dat_o = sel_line_i[word_cnt_q*dcache_pkg::WORD_WIDTH +: dcache_pkg::WORD_WIDTH];

endmodule

// File: dcache/dcache_top.sv
module dcache_top (
  input  logic                  clk,
  input  logic                  rst_n,
  // core request
  input  logic                  req_valid_i,
  input  logic                  req_we_i,
  input  dcache_pkg::addr_t     req_addr_i,
  input  dcache_pkg::mem_size_e req_size_i,
  input  logic                  req_signed_i,
  input  dcache_pkg::word_t     req_wdata_i,
  output logic                  req_ready_o,
  // core response
  output logic                  rsp_valid_o,
  output dcache_pkg::word_t     rsp_rdata_o,
  // wishbone master
  output logic                  wb_cyc_o,
  output logic                  wb_stb_o,
  output logic                  wb_we_o,
  output dcache_pkg::addr_t     wb_adr_o,
  output dcache_pkg::word_t     wb_dat_o,
  output dcache_pkg::strb_t     wb_sel_o,
  input  dcache_pkg::word_t     wb_dat_i,
  input  logic                  wb_ack_i
);

  // controller to ways
  dcache_pkg::idx_t idx;
  dcache_pkg::tag_t lookup_tag;
  logic [dcache_pkg::WAY_NUM-1:0] way_we;
  dcache_pkg::tag_t wr_tag;
  dcache_pkg::line_t wr_line;
  logic wr_dirty;

  // ways to hit selector
  logic [dcache_pkg::WAY_NUM-1:0] hit_vec;
  logic [dcache_pkg::WAY_NUM-1:0] dirty_vec;
  dcache_pkg::tag_t [dcache_pkg::WAY_NUM-1:0] tags;
  dcache_pkg::line_t [dcache_pkg::WAY_NUM-1:0] lines;

  // hit selector to controller
  logic hit;
  dcache_pkg::way_t hit_way;
  dcache_pkg::way_t victim_way;
  logic victim_dirty;
  dcache_pkg::tag_t victim_tag;
  dcache_pkg::line_t sel_line;

  // load extraction controls
  dcache_pkg::wsel_t wsel;
  dcache_pkg::mem_size_e size;
  logic is_signed;
  logic [1:0] byte_ofs;

  dcache_ctrl dcache_ctrl_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid_i    (req_valid_i),
    .req_we_i       (req_we_i),
    .req_addr_i     (req_addr_i),
    .req_size_i     (req_size_i),
    .req_signed_i   (req_signed_i),
    .req_wdata_i    (req_wdata_i),
    .req_ready_o    (req_ready_o),
    .rsp_valid_o    (rsp_valid_o),
    .idx_o          (idx),
    .lookup_tag_o   (lookup_tag),
    .way_we_o       (way_we),
    .wr_tag_o       (wr_tag),
    .wr_line_o      (wr_line),
    .wr_dirty_o     (wr_dirty),
    .victim_way_o   (victim_way),
    .hit_i          (hit),
    .hit_way_i      (hit_way),
    .victim_dirty_i (victim_dirty),
    .victim_tag_i   (victim_tag),
    .sel_line_i     (sel_line),
    .wb_cyc_o       (wb_cyc_o),
    .wb_stb_o       (wb_stb_o),
    .wb_we_o        (wb_we_o),
    .wb_adr_o       (wb_adr_o),
    .wb_dat_o       (wb_dat_o),
    .wb_sel_o       (wb_sel_o),
    .wb_dat_i       (wb_dat_i),
    .wb_ack_i       (wb_ack_i),
    .wsel_o         (wsel),
    .size_o         (size),
    .signed_o       (is_signed),
    .byte_ofs_o     (byte_ofs)
  );

  for (genvar i = 0; i < dcache_pkg::WAY_NUM; i++) begin : gen_way
    dcache_way dcache_way_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .idx_i        (idx),
      .lookup_tag_i (lookup_tag),
      .we_i         (way_we[i]),
      .wr_tag_i     (wr_tag),
      .wr_line_i    (wr_line),
      .wr_dirty_i   (wr_dirty),
      .hit_o        (hit_vec[i]),
      .dirty_o      (dirty_vec[i]),
      .tag_o        (tags[i]),
      .line_o       (lines[i])
    );
  end

  dcache_hit_select dcache_hit_select_inst (
    .hit_vec_i      (hit_vec),
    .lines_i        (lines),
    .tags_i         (tags),
    .dirty_vec_i    (dirty_vec),
    .victim_way_i   (victim_way),
    .wsel_i         (wsel),
    .byte_ofs_i     (byte_ofs),
    .size_i         (size),
    .signed_i       (is_signed),
    .hit_o          (hit),
    .hit_way_o      (hit_way),
    .victim_dirty_o (victim_dirty),
    .victim_tag_o   (victim_tag),
    .sel_line_o     (sel_line),
    .rdata_o        (rsp_rdata_o)
  );

endmodule

// File: dcache/dcache_way.sv
module dcache_way (
  input  logic              clk,
  input  logic              rst_n,
  input  dcache_pkg::idx_t  idx_i,
  input  dcache_pkg::tag_t  lookup_tag_i,
  input  logic              we_i,
  input  dcache_pkg::tag_t  wr_tag_i,
  input  dcache_pkg::line_t wr_line_i,
  input  logic              wr_dirty_i,
  output logic              hit_o,
  output logic              dirty_o,
  output dcache_pkg::tag_t  tag_o,
  output dcache_pkg::line_t line_o
);

  // per-set storage
  dcache_pkg::tag_t  tag_q  [2**dcache_pkg::IDX_WIDTH];
  dcache_pkg::line_t line_q [2**dcache_pkg::IDX_WIDTH];

  logic [2**dcache_pkg::IDX_WIDTH-1:0] valid_q;
  logic [2**dcache_pkg::IDX_WIDTH-1:0] dirty_q;

  // ========================================
  // status bits
  // ========================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (we_i) begin
      valid_q[idx_i] <= 1'b1;
      dirty_q[idx_i] <= wr_dirty_i;
    end
  end

  // tag and data arrays
  always_ff @(posedge clk) begin
    if (we_i) begin
      tag_q[idx_i]  <= wr_tag_i;
      line_q[idx_i] <= wr_line_i;
    end
  end

  // ========================================
  // lookup
  // ========================================

  // read side is asynchronous from the index
  assign tag_o   = tag_q[idx_i];
  assign line_o  = line_q[idx_i];
  assign dirty_o = dirty_q[idx_i];

  assign hit_o = valid_q[idx_i] && (tag_q[idx_i] == lookup_tag_i);

endmodule

// File: logic/dcache_hit_select.sv
module dcache_hit_select (
  input  logic [dcache_pkg::WAY_NUM-1:0]                      hit_vec_i,
  input  dcache_pkg::line_t [dcache_pkg::WAY_NUM-1:0]         lines_i,
  input  dcache_pkg::tag_t [dcache_pkg::WAY_NUM-1:0]          tags_i,
  input  logic [dcache_pkg::WAY_NUM-1:0]                      dirty_vec_i,
  input  dcache_pkg::way_t                                    victim_way_i,
  input  dcache_pkg::wsel_t                                   wsel_i,
  input  logic [1:0]                                          byte_ofs_i,
  input  dcache_pkg::mem_size_e                               size_i,
  input  logic                                                signed_i,
  output logic                                                hit_o,
  output dcache_pkg::way_t                                    hit_way_o,
  output logic                                                victim_dirty_o,
  output dcache_pkg::tag_t                                    victim_tag_o,
  output dcache_pkg::line_t                                   sel_line_o,
  output dcache_pkg::word_t                                   rdata_o
);

  dcache_pkg::word_t word;
  logic [7:0] load_byte;
  logic [15:0] load_half;

  // ========================================
  // way selection
  // ========================================

  // at most one way hits, so the last match wins
  always_comb begin
    hit_o     = 1'b0;
    hit_way_o = '0;
    for (int i = 0; i < dcache_pkg::WAY_NUM; i++) begin
      if (hit_vec_i[i]) begin
        hit_o     = 1'b1;
        hit_way_o = dcache_pkg::way_t'(i);
      end
    end
  end

  assign victim_dirty_o = dirty_vec_i[victim_way_i];
  assign victim_tag_o   = tags_i[victim_way_i];

  // victim line feeds write-back on a miss
  assign sel_line_o = hit_o ? lines_i[hit_way_o] : lines_i[victim_way_i];

  // ========================================
  // load extraction
  // ========================================

  assign word = sel_line_o[wsel_i*dcache_pkg::WORD_WIDTH +: dcache_pkg::WORD_WIDTH];

  // accesses are aligned, so the half sits at offset 0 or 2
  assign load_byte = word[byte_ofs_i*8 +: 8];
  assign load_half = word[byte_ofs_i[1]*16 +: 16];

  always_comb begin
    case (size_i)
      dcache_pkg::SIZE_BYTE: begin
        rdata_o = {{24{signed_i & load_byte[7]}}, load_byte};
      end
      dcache_pkg::SIZE_HALF: begin
        rdata_o = {{16{signed_i & load_half[15]}}, load_half};
      end
      default: begin
        rdata_o = word;
      end
    endcase
  end

endmodule

// File: tb/tb_dcache.sv
module tb_dcache;

  localparam int NUM_TESTS = 22;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * 200 + 100;

  logic                  clk;
  logic                  rst_n;
  logic                  req_valid;
  logic                  req_we;
  dcache_pkg::addr_t     req_addr;
  dcache_pkg::mem_size_e req_size;
  logic                  req_signed;
  dcache_pkg::word_t     req_wdata;
  logic                  req_ready;
  logic                  rsp_valid;
  dcache_pkg::word_t     rsp_rdata;

  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  dcache_pkg::addr_t wb_adr;
  dcache_pkg::word_t wb_dat_w;
  dcache_pkg::strb_t wb_sel;
  dcache_pkg::word_t wb_dat_r;
  logic              wb_ack;

  logic [1:0]  mem_delay;
  logic [31:0] lfsr;
  logic [31:0] read_count;
  logic [31:0] write_count;

  // stimulus table
  string                 t_name    [NUM_TESTS];
  logic                  t_we      [NUM_TESTS];
  dcache_pkg::addr_t     t_addr    [NUM_TESTS];
  dcache_pkg::mem_size_e t_size    [NUM_TESTS];
  logic                  t_signed  [NUM_TESTS];
  dcache_pkg::word_t     t_wdata   [NUM_TESTS];
  dcache_pkg::word_t     t_rdata   [NUM_TESTS];
  int                    t_dreads  [NUM_TESTS];
  int                    t_dwrites [NUM_TESTS];
  int                    table_len;

  int pass_count;
  int fail_count;

  dcache_top dcache_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid),
    .req_we_i     (req_we),
    .req_addr_i   (req_addr),
    .req_size_i   (req_size),
    .req_signed_i (req_signed),
    .req_wdata_i  (req_wdata),
    .req_ready_o  (req_ready),
    .rsp_valid_o  (rsp_valid),
    .rsp_rdata_o  (rsp_rdata),
    .wb_cyc_o     (wb_cyc),
    .wb_stb_o     (wb_stb),
    .wb_we_o      (wb_we),
    .wb_adr_o     (wb_adr),
    .wb_dat_o     (wb_dat_w),
    .wb_sel_o     (wb_sel),
    .wb_dat_i     (wb_dat_r),
    .wb_ack_i     (wb_ack)
  );

  wb_mem_model wb_mem_model_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .cyc_i         (wb_cyc),
    .stb_i         (wb_stb),
    .we_i          (wb_we),
    .adr_i         (wb_adr),
    .dat_i         (wb_dat_w),
    .sel_i         (wb_sel),
    .delay_i       (mem_delay),
    .dat_o         (wb_dat_r),
    .ack_o         (wb_ack),
    .read_count_o  (read_count),
    .write_count_o (write_count)
  );

  // ========================================
  // helpers
  // ========================================

  // fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // initial memory contents are the word address xor a constant
  function automatic dcache_pkg::word_t pattern_word(input dcache_pkg::addr_t a);
    return {2'b00, a[31:2]} ^ 32'h5a5a0000;
  endfunction

  task automatic add_entry(input string name, input logic we, input dcache_pkg::addr_t addr,
                           input dcache_pkg::mem_size_e size, input logic sgn,
                           input dcache_pkg::word_t wdata, input dcache_pkg::word_t rdata,
                           input int dreads, input int dwrites);
    t_name[table_len]    = name;
    t_we[table_len]      = we;
    t_addr[table_len]    = addr;
    t_size[table_len]    = size;
    t_signed[table_len]  = sgn;
    t_wdata[table_len]   = wdata;
    t_rdata[table_len]   = rdata;
    t_dreads[table_len]  = dreads;
    t_dwrites[table_len] = dwrites;
    table_len++;
  endtask

  // lines A B C D all sit in set 3
  task automatic build_table();
    add_entry("load_miss_a", 0, 32'h1030, dcache_pkg::SIZE_WORD, 0, 0,
              pattern_word(32'h1030), 4, 0);
    add_entry("store_byte_a", 1, 32'h1031, dcache_pkg::SIZE_BYTE, 0, 32'h000000a5, 0, 0, 0);
    add_entry("store_half_a", 1, 32'h1032, dcache_pkg::SIZE_HALF, 0, 32'h00008001, 0, 0, 0);
    add_entry("store_word_a", 1, 32'h1034, dcache_pkg::SIZE_WORD, 0, 32'h12345678, 0, 0, 0);
    add_entry("load_word_a", 0, 32'h1030, dcache_pkg::SIZE_WORD, 0, 0, 32'h8001a50c, 0, 0);
    add_entry("load_byte_s", 0, 32'h1031, dcache_pkg::SIZE_BYTE, 1, 0, 32'hffffffa5, 0, 0);
    add_entry("load_byte_u", 0, 32'h1031, dcache_pkg::SIZE_BYTE, 0, 0, 32'h000000a5, 0, 0);
    add_entry("load_half_s", 0, 32'h1032, dcache_pkg::SIZE_HALF, 1, 0, 32'hffff8001, 0, 0);
    add_entry("load_half_u", 0, 32'h1032, dcache_pkg::SIZE_HALF, 0, 0, 32'h00008001, 0, 0);
    add_entry("load_half_s_pos", 0, 32'h1036, dcache_pkg::SIZE_HALF, 1, 0, 32'h00001234, 0, 0);
    add_entry("load_byte_s_pos", 0, 32'h1034, dcache_pkg::SIZE_BYTE, 1, 0, 32'h00000078, 0, 0);
    add_entry("load_miss_b", 0, 32'h2030, dcache_pkg::SIZE_WORD, 0, 0,
              pattern_word(32'h2030), 4, 0);
    // A is dirty and least recently hit
    add_entry("evict_dirty_a", 0, 32'h3030, dcache_pkg::SIZE_WORD, 0, 0,
              pattern_word(32'h3030), 4, 4);
    add_entry("touch_b", 0, 32'h2030, dcache_pkg::SIZE_WORD, 0, 0,
              pattern_word(32'h2030), 0, 0);
    // C is now the victim, clean
    add_entry("reload_a", 0, 32'h1030, dcache_pkg::SIZE_WORD, 0, 0, 32'h8001a50c, 4, 0);
    add_entry("reload_a_word1", 0, 32'h1034, dcache_pkg::SIZE_WORD, 0, 0, 32'h12345678, 0, 0);
    add_entry("hit_b", 0, 32'h2030, dcache_pkg::SIZE_WORD, 0, 0, pattern_word(32'h2030), 0, 0);
    add_entry("touch_a", 0, 32'h1030, dcache_pkg::SIZE_WORD, 0, 0, 32'h8001a50c, 0, 0);
    add_entry("touch_b_again", 0, 32'h2030, dcache_pkg::SIZE_WORD, 0, 0,
              pattern_word(32'h2030), 0, 0);
    // B was hit last, so D replaces A
    add_entry("evict_lru_d", 0, 32'h4030, dcache_pkg::SIZE_WORD, 0, 0,
              pattern_word(32'h4030), 4, 0);
    add_entry("keep_b", 0, 32'h2030, dcache_pkg::SIZE_WORD, 0, 0, pattern_word(32'h2030), 0, 0);
    add_entry("evicted_a", 0, 32'h1030, dcache_pkg::SIZE_WORD, 0, 0, 32'h8001a50c, 4, 0);
  endtask

  task automatic check_reset_state();
    logic ok;
    ok = 1'b1;
    @(negedge clk);
    assert (req_ready && !rsp_valid && !wb_cyc && !wb_stb) else begin
      $display("reset_state: ready %0b rsp_valid %0b wb_cyc %0b wb_stb %0b wrong after reset",
               req_ready, rsp_valid, wb_cyc, wb_stb);
      ok = 1'b0;
    end
    if (ok) begin
      pass_count++;
      $display("test reset_state ok");
    end else begin
      fail_count++;
      $display("test reset_state FAIL");
    end
    @(posedge clk);
    #1;
  endtask

  // called 1 unit after a rising edge and returns at the same phase
  task automatic apply_entry(input int i);
    int reads_before;
    int writes_before;
    int d_reads;
    int d_writes;
    dcache_pkg::word_t rdata;
    logic ok;
    ok            = 1'b1;
    reads_before  = int'(read_count);
    writes_before = int'(write_count);
    req_valid  = 1'b1;
    req_we     = t_we[i];
    req_addr   = t_addr[i];
    req_size   = t_size[i];
    req_signed = t_signed[i];
    req_wdata  = t_wdata[i];
    @(negedge clk);
    while (!req_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    @(negedge clk);
    while (!rsp_valid) begin
      @(negedge clk);
    end
    rdata    = rsp_rdata;
    d_reads  = int'(read_count) - reads_before;
    d_writes = int'(write_count) - writes_before;
    @(posedge clk);
    #1;

    if (!t_we[i]) begin
      assert (rdata == t_rdata[i]) else begin
        $display("mismatch %s rdata expected %08h actual %08h", t_name[i], t_rdata[i], rdata);
        ok = 1'b0;
      end
    end
    assert (d_reads == t_dreads[i]) else begin
      $display("mismatch %s bus reads expected %0d actual %0d", t_name[i], t_dreads[i], d_reads);
      ok = 1'b0;
    end
    assert (d_writes == t_dwrites[i]) else begin
      $display("mismatch %s bus writes expected %0d actual %0d",
               t_name[i], t_dwrites[i], d_writes);
      ok = 1'b0;
    end

    if (ok) begin
      pass_count++;
      $display("test %s ok", t_name[i]);
    end else begin
      fail_count++;
      $display("test %s FAIL", t_name[i]);
    end
  endtask

  // ========================================
  // clock, wait states, watchdog
  // ========================================

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // two LFSR bits per cycle form the next wait-state count
  initial begin
    lfsr      = 32'haccee5f1;
    mem_delay = 2'd0;
    forever begin
      @(posedge clk);
      #1;
      lfsr         = lfsr_next(lfsr);
      mem_delay[0] = lfsr[0];
      lfsr         = lfsr_next(lfsr);
      mem_delay[1] = lfsr[0];
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: the cache did not finish all tests within %0d cycles", TIMEOUT_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  // ========================================
  // main sequence
  // ========================================

  initial begin
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req_we     = 1'b0;
    req_addr   = '0;
    req_size   = dcache_pkg::SIZE_WORD;
    req_signed = 1'b0;
    req_wdata  = '0;
    table_len  = 0;
    pass_count = 0;
    fail_count = 0;
    build_table();

    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_reset_state();

    for (int i = 0; i < NUM_TESTS; i++) begin
      apply_entry(i);
    end

    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: tb/wb_mem_model.sv
module wb_mem_model (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cyc_i,
  input  logic              stb_i,
  input  logic              we_i,
  input  dcache_pkg::addr_t adr_i,
  input  dcache_pkg::word_t dat_i,
  input  dcache_pkg::strb_t sel_i,
  input  logic [1:0]        delay_i,
  output dcache_pkg::word_t dat_o,
  output logic              ack_o,
  output logic [31:0]       read_count_o,
  output logic [31:0]       write_count_o
);

  // only words that were written live here, keyed by word address
  dcache_pkg::word_t mem [logic [29:0]];

  logic       busy;
  logic [1:0] wait_cnt;

  // untouched words follow the fill pattern
  function automatic dcache_pkg::word_t fetch_word(input logic [29:0] wadr);
    if (mem.exists(wadr)) begin
      return mem[wadr];
    end
    return {2'b00, wadr} ^ 32'h5a5a0000;
  endfunction

  task automatic store_word(input logic [29:0] wadr, input dcache_pkg::word_t data,
                            input dcache_pkg::strb_t sel);
    dcache_pkg::word_t merged;
    merged = fetch_word(wadr);
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        merged[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    mem[wadr] = merged;
  endtask

  // ========================================
  // slave handshake
  // ========================================

  // delay_i is taken at the start of each transfer as the wait-state count
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_o         <= 1'b0;
      busy          <= 1'b0;
      wait_cnt      <= '0;
      dat_o         <= '0;
      read_count_o  <= '0;
      write_count_o <= '0;
    end else begin
      ack_o <= 1'b0;
      if (cyc_i && stb_i && !ack_o) begin
        if (!busy && delay_i != 2'd0) begin
          busy     <= 1'b1;
          wait_cnt <= delay_i - 2'd1;
        end else if (busy && wait_cnt != 2'd0) begin
          wait_cnt <= wait_cnt - 2'd1;
        end else begin
          busy  <= 1'b0;
          ack_o <= 1'b1;
          if (we_i) begin
            store_word(adr_i[31:2], dat_i, sel_i);
            write_count_o <= write_count_o + 32'd1;
          end else begin
            dat_o        <= fetch_word(adr_i[31:2]);
            read_count_o <= read_count_o + 32'd1;
          end
        end
      end
    end
  end

endmodule
